// ==== Makefile ====
# Verilator build and run for the dual commit stage

SIM := obj_dir/Vtb_dual_commit

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): dual_commit.f rtl/commit_defines.svh rtl/commit_pkg.sv rtl/alu_lane.sv \
        rtl/regfile.sv rtl/rfwrite_queue.sv rtl/dual_commit.sv verif/tb_dual_commit.sv
	verilator --binary --timing --timescale 1ns/1ps -f dual_commit.f \
		--top-module tb_dual_commit -o Vtb_dual_commit

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	cat sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dual_commit.f ====
+incdir+rtl
rtl/commit_pkg.sv
rtl/alu_lane.sv
rtl/regfile.sv
rtl/rfwrite_queue.sv
rtl/dual_commit.sv
verif/tb_dual_commit.sv

// ==== rtl/alu_lane.sv ====
`timescale 1ns/1ps
`include "commit_defines.svh"

module alu_lane (
    input  logic                   clk,
    input  logic                   reset,
    input  commit_pkg::slot_t      slot,
    output commit_pkg::creg_addr_t rs_addr,
    output commit_pkg::creg_addr_t rt_addr,
    input  commit_pkg::word_t      rs_data,
    input  commit_pkg::word_t      rt_data,
    input  commit_pkg::rf_w_t      older_w,
    output commit_pkg::rf_w_t      comb_w,
    output commit_pkg::lane_res_t  res
);

    logic                   is_rtype;
    commit_pkg::word_t      op_a;
    commit_pkg::word_t      op_b;
    commit_pkg::word_t      imm_sext;
    commit_pkg::word_t      imm_zext;
    commit_pkg::word_t      imm_lui;
    commit_pkg::word_t      alu_out;
    logic                   wr_en;
    commit_pkg::creg_addr_t wr_addr;
    logic                   slt_lt;

    // opcode field sits in the same bits for both views
    assign is_rtype = (slot.inst.r_fmt.opcode == commit_pkg::OP_SPECIAL);

    // source register numbers, same bits in both views
    assign rs_addr = slot.inst.i_fmt.rs;
    assign rt_addr = slot.inst.i_fmt.rt;

    // forward from the older slot of the same pair
    // r0 never forwards, it always reads zero
    always_comb begin
        op_a = rs_data;
        op_b = rt_data;
        if (older_w.wen && (older_w.addr != '0) && (older_w.addr == rs_addr)) begin
            op_a = older_w.wd;
        end
        if (older_w.wen && (older_w.addr != '0) && (older_w.addr == rt_addr)) begin
            op_b = older_w.wd;
        end
    end

    // immediate forms
    assign imm_sext = {{(`COMMIT_XLEN-16){slot.inst.i_fmt.imm16[15]}}, slot.inst.i_fmt.imm16};
    assign imm_zext = {{(`COMMIT_XLEN-16){1'b0}}, slot.inst.i_fmt.imm16};
    assign imm_lui  = {slot.inst.i_fmt.imm16, {(`COMMIT_XLEN-16){1'b0}}};

    // signed compare for slt
    assign slt_lt = ($signed(op_a) < $signed(op_b));

    // execute
    always_comb begin
        alu_out = '0;
        wr_en   = 1'b0;
        if (is_rtype) begin
            // r-type writes rd
            wr_addr = slot.inst.r_fmt.rd;
            wr_en   = 1'b1;
            case (slot.inst.r_fmt.funct)
                commit_pkg::FN_ADDU: alu_out = op_a + op_b;
                commit_pkg::FN_SUBU: alu_out = op_a - op_b;
                commit_pkg::FN_AND:  alu_out = op_a & op_b;
                commit_pkg::FN_OR:   alu_out = op_a | op_b;
                commit_pkg::FN_XOR:  alu_out = op_a ^ op_b;
                commit_pkg::FN_SLT:  alu_out = {{(`COMMIT_XLEN-1){1'b0}}, slt_lt};
                // unknown funct retires as nop
                default:             wr_en = 1'b0;
            endcase
        end else begin
            // i-type writes rt
            wr_addr = slot.inst.i_fmt.rt;
            wr_en   = 1'b1;
            case (slot.inst.i_fmt.opcode)
                commit_pkg::OP_ADDIU: alu_out = op_a + imm_sext;
                commit_pkg::OP_ORI:   alu_out = op_a | imm_zext;
                commit_pkg::OP_LUI:   alu_out = imm_lui;
                default:              wr_en = 1'b0;
            endcase
        end
    end

    // write request seen by the younger lane and the result register
    always_comb begin
        comb_w.wen  = slot.valid & wr_en;
        comb_w.addr = wr_addr;
        comb_w.wd   = alu_out;
    end

    // result register, one cycle after issue
    always_ff @(posedge clk) begin
        if (reset) begin
            res <= '0;
        end else begin
            res.valid <= slot.valid;
            res.pc    <= slot.pc;
            res.rfw   <= comb_w;
        end
    end

endmodule

// ==== rtl/commit_defines.svh ====
`ifndef COMMIT_DEFINES_SVH
`define COMMIT_DEFINES_SVH

// data path and pc width
`define COMMIT_XLEN 32

// architectural registers, r0 reads as zero
`define COMMIT_NREGS 32

// retire queue entries
// must be a power of two, at least 4
// two slots per pair need two free entries
`define RETIRE_QUEUE_DEPTH 8

`endif

// ==== rtl/commit_pkg.sv ====
`include "commit_defines.svh"

package commit_pkg;

    // basic scalar types
    typedef logic [`COMMIT_XLEN-1:0] word_t;
    typedef logic [$clog2(`COMMIT_NREGS)-1:0] creg_addr_t;
    // byte write enable, same shape as the debug port
    typedef logic [3:0] rwen_t;
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // mips r-type layout
    typedef struct packed {
        opcode_t    opcode;
        creg_addr_t rs;
        creg_addr_t rt;
        creg_addr_t rd;
        logic [4:0] shamt;
        funct_t     funct;
    } r_fmt_t;

    // mips i-type layout
    typedef struct packed {
        opcode_t     opcode;
        creg_addr_t  rs;
        creg_addr_t  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    // one instruction word, two views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } inst_u;

    // one issue slot, valid low means bubble
    typedef struct packed {
        logic  valid;
        word_t pc;
        inst_u inst;
    } slot_t;

    // register write request
    typedef struct packed {
        logic       wen;
        creg_addr_t addr;
        word_t      wd;
    } rf_w_t;

    // registered lane output
    typedef struct packed {
        logic  valid;
        word_t pc;
        rf_w_t rfw;
    } lane_res_t;

    // primary opcodes
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_LUI     = 6'b001111;

    // special funct codes
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_SLT  = 6'b101010;

endpackage

// ==== rtl/dual_commit.sv ====
`timescale 1ns/1ps

module dual_commit (
    input  logic                   clk,
    input  logic                   reset,
    input  commit_pkg::slot_t      slot0,
    input  commit_pkg::slot_t      slot1,
    output logic                   issue_stall,
    output commit_pkg::word_t      debug_wb_pc,
    output commit_pkg::rwen_t      debug_wb_rf_wen,
    output commit_pkg::creg_addr_t debug_wb_rf_wnum,
    output commit_pkg::word_t      debug_wb_rf_wdata
);

    commit_pkg::slot_t      slot0_g;
    commit_pkg::slot_t      slot1_g;
    commit_pkg::rf_w_t      lane0_w;
    commit_pkg::lane_res_t  res0;
    commit_pkg::lane_res_t  res1;
    commit_pkg::creg_addr_t rf_raddr [4];
    commit_pkg::word_t      rf_rdata [4];

    // slots offered during a stall are dropped here
    always_comb begin
        slot0_g       = slot0;
        slot1_g       = slot1;
        slot0_g.valid = slot0.valid & ~issue_stall;
        slot1_g.valid = slot1.valid & ~issue_stall;
    end

    // older lane, ports 0 and 1
    // nothing older to forward from
    alu_lane i_lane0 (
        .clk,
        .reset,
        .slot    (slot0_g),
        .rs_addr (rf_raddr[0]),
        .rt_addr (rf_raddr[1]),
        .rs_data (rf_rdata[0]),
        .rt_data (rf_rdata[1]),
        .older_w ('0),
        .comb_w  (lane0_w),
        .res     (res0)
    );

    // younger lane, ports 2 and 3
    // its own comb write has no consumer
    alu_lane i_lane1 (
        .clk,
        .reset,
        .slot    (slot1_g),
        .rs_addr (rf_raddr[2]),
        .rt_addr (rf_raddr[3]),
        .rs_data (rf_rdata[2]),
        .rt_data (rf_rdata[3]),
        .older_w (lane0_w),
        .comb_w  (),
        .res     (res1)
    );

    // writeback from the lane result registers
    regfile i_regfile (
        .clk,
        .reset,
        .raddr (rf_raddr),
        .rdata (rf_rdata),
        .w0    (res0.rfw),
        .w1    (res1.rfw)
    );

    // in-order trace, slot0 before slot1
    rfwrite_queue i_rfwrite_queue (
        .clk,
        .reset,
        .res0,
        .res1,
        .issue_stall,
        .debug_wb_pc,
        .debug_wb_rf_wen,
        .debug_wb_rf_wnum,
        .debug_wb_rf_wdata
    );

endmodule

// ==== rtl/regfile.sv ====
`timescale 1ns/1ps
`include "commit_defines.svh"

module regfile (
    input  logic                   clk,
    input  logic                   reset,
    input  commit_pkg::creg_addr_t raddr [4],
    output commit_pkg::word_t      rdata [4],
    input  commit_pkg::rf_w_t      w0,
    input  commit_pkg::rf_w_t      w1
);

    localparam int NRP = 4;

    commit_pkg::word_t regs [`COMMIT_NREGS];
    logic              w0_live;
    logic              w1_live;

    // r0 writes are dropped
    assign w0_live = w0.wen && (w0.addr != '0);
    assign w1_live = w1.wen && (w1.addr != '0);

    // write port, w1 is younger so it lands last
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `COMMIT_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (w0_live) begin
                regs[w0.addr] <= w0.wd;
            end
            if (w1_live) begin
                regs[w1.addr] <= w1.wd;
            end
        end
    end

    // read ports with write-through
    // younger write checked first
    always_comb begin
        for (int p = 0; p < NRP; p++) begin
            if (raddr[p] == '0) begin
                rdata[p] = '0;
            end else if (w1_live && (w1.addr == raddr[p])) begin
                rdata[p] = w1.wd;
            end else if (w0_live && (w0.addr == raddr[p])) begin
                rdata[p] = w0.wd;
            end else begin
                rdata[p] = regs[raddr[p]];
            end
        end
    end

endmodule

// ==== rtl/rfwrite_queue.sv ====
`timescale 1ns/1ps
`include "commit_defines.svh"

module rfwrite_queue (
    input  logic                   clk,
    input  logic                   reset,
    input  commit_pkg::lane_res_t  res0,
    input  commit_pkg::lane_res_t  res1,
    output logic                   issue_stall,
    output commit_pkg::word_t      debug_wb_pc,
    output commit_pkg::rwen_t      debug_wb_rf_wen,
    output commit_pkg::creg_addr_t debug_wb_rf_wnum,
    output commit_pkg::word_t      debug_wb_rf_wdata
);

    localparam int DEPTH = `RETIRE_QUEUE_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam int CW    = AW + 1;

    commit_pkg::lane_res_t mem [DEPTH];
    commit_pkg::lane_res_t head_ent;
    logic [AW-1:0]         head;
    logic [AW-1:0]         tail;
    logic [AW-1:0]         tail_plus1;
    logic [AW-1:0]         res1_slot;
    logic [CW-1:0]         count;
    logic [CW-1:0]         count_next;
    logic [1:0]            n_push;
    logic                  pop;

    // one retirement per cycle while anything is stored
    assign pop      = (count != '0);
    assign head_ent = mem[head];

    // 0, 1 or 2 pushes this cycle
    assign n_push = {1'b0, res0.valid} + {1'b0, res1.valid};

    // pointers wrap on their own, depth is a power of two
    assign tail_plus1 = tail + AW'(1);
    // slot1 result follows slot0 when both are present
    assign res1_slot  = res0.valid ? tail_plus1 : tail;

    assign count_next = count + CW'(n_push) - CW'(pop);

    // need room for a full pair next edge
    assign issue_stall = (count_next > CW'(DEPTH - 2));

    // entry storage
    always_ff @(posedge clk) begin
        if (res0.valid) begin
            mem[tail] <= res0;
        end
        if (res1.valid) begin
            mem[res1_slot] <= res1;
        end
    end

    // head, tail, occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            tail  <= tail + AW'(n_push);
            count <= count_next;
            if (pop) begin
                head <= head + AW'(1);
            end
        end
    end

    // registered debug trace
    // pc of zero marks an idle cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            debug_wb_pc       <= '0;
            debug_wb_rf_wen   <= '0;
            debug_wb_rf_wnum  <= '0;
            debug_wb_rf_wdata <= '0;
        end else if (pop) begin
            debug_wb_pc       <= head_ent.pc;
            // full word enable only for a real register
            debug_wb_rf_wen   <= {4{head_ent.rfw.wen && (head_ent.rfw.addr != '0)}};
            debug_wb_rf_wnum  <= head_ent.rfw.addr;
            debug_wb_rf_wdata <= head_ent.rfw.wd;
        end else begin
            debug_wb_pc       <= '0;
            debug_wb_rf_wen   <= '0;
            debug_wb_rf_wnum  <= '0;
            debug_wb_rf_wdata <= '0;
        end
    end

endmodule

// ==== verif/tb_dual_commit.sv ====
`timescale 1ns/1ps
`include "commit_defines.svh"

module tb_dual_commit;

    localparam int DRIVE_DLY       = 10;
    localparam int RAND_CYCLES     = 2000;
    localparam int DIRECTED_CYCLES = 300;
    // directed and random issue cycles plus drain margin
    localparam int MAX_CYCLES      = RAND_CYCLES + DIRECTED_CYCLES + 200;
    // a full queue plus the lane and trace registers
    localparam int DRAIN_LIMIT     = 2 * `RETIRE_QUEUE_DEPTH + 8;

    // one expected debug trace record
    typedef struct packed {
        commit_pkg::word_t      pc;
        commit_pkg::rwen_t      wen;
        commit_pkg::creg_addr_t wnum;
        commit_pkg::word_t      wdata;
    } trace_t;

    logic                   clk;
    logic                   reset;
    commit_pkg::slot_t      slot0;
    commit_pkg::slot_t      slot1;
    logic                   issue_stall;
    commit_pkg::word_t      debug_wb_pc;
    commit_pkg::rwen_t      debug_wb_rf_wen;
    commit_pkg::creg_addr_t debug_wb_rf_wnum;
    commit_pkg::word_t      debug_wb_rf_wdata;

    commit_pkg::word_t model_regs [`COMMIT_NREGS];
    trace_t            exp_q [$];
    trace_t            exp_rec;
    commit_pkg::word_t next_pc;
    logic [31:0]       lfsr;
    logic              stall_seen;
    int                cycles;

    dual_commit i_dut (
        .clk,
        .reset,
        .slot0,
        .slot1,
        .issue_stall,
        .debug_wb_pc,
        .debug_wb_rf_wen,
        .debug_wb_rf_wnum,
        .debug_wb_rf_wdata
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    // instruction encoders
    function automatic logic [31:0] r_inst(input logic [5:0] fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd);
        return {commit_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_inst(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // reference model, one instruction against model_regs
    function automatic commit_pkg::rf_w_t ref_exec(input logic [31:0] inst);
        commit_pkg::rf_w_t      w;
        commit_pkg::word_t      a;
        commit_pkg::word_t      b;
        logic [15:0]            imm;
        commit_pkg::creg_addr_t rs;
        commit_pkg::creg_addr_t rt;
        rs  = inst[25:21];
        rt  = inst[20:16];
        imm = inst[15:0];
        a   = model_regs[rs];
        b   = model_regs[rt];
        w   = '0;
        w.wen = 1'b1;
        if (inst[31:26] == commit_pkg::OP_SPECIAL) begin
            // r-type, result to rd
            w.addr = inst[15:11];
            case (inst[5:0])
                commit_pkg::FN_ADDU: w.wd = a + b;
                commit_pkg::FN_SUBU: w.wd = a - b;
                commit_pkg::FN_AND:  w.wd = a & b;
                commit_pkg::FN_OR:   w.wd = a | b;
                commit_pkg::FN_XOR:  w.wd = a ^ b;
                commit_pkg::FN_SLT:  w.wd = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default:             w.wen = 1'b0;
            endcase
        end else begin
            // i-type, result to rt
            w.addr = rt;
            case (inst[31:26])
                commit_pkg::OP_ADDIU: w.wd = a + {{16{imm[15]}}, imm};
                commit_pkg::OP_ORI:   w.wd = a | {16'h0000, imm};
                commit_pkg::OP_LUI:   w.wd = {imm, 16'h0000};
                default:              w.wen = 1'b0;
            endcase
        end
        return w;
    endfunction

    // expected trace entry, then commit to the model
    function automatic void record_slot(input commit_pkg::word_t pc_v, input logic [31:0] inst);
        commit_pkg::rf_w_t w;
        trace_t            t;
        w       = ref_exec(inst);
        t.pc    = pc_v;
        t.wen   = (w.wen && (w.addr != '0)) ? 4'hf : 4'h0;
        t.wnum  = w.addr;
        t.wdata = w.wd;
        exp_q.push_back(t);
        if (t.wen != '0) begin
            model_regs[w.addr] = w.wd;
        end
    endfunction

    // random op mix, small register range for frequent hazards
    function automatic logic [31:0] rand_inst();
        logic [31:0]            sel;
        commit_pkg::creg_addr_t rs;
        commit_pkg::creg_addr_t rt;
        commit_pkg::creg_addr_t rd;
        logic [15:0]            imm;
        sel = take_bits(4);
        rs  = commit_pkg::creg_addr_t'(take_bits(3));
        rt  = commit_pkg::creg_addr_t'(take_bits(3));
        rd  = commit_pkg::creg_addr_t'(take_bits(3));
        imm = 16'(take_bits(16));
        case (sel)
            0:       return r_inst(commit_pkg::FN_ADDU, rs, rt, rd);
            1:       return r_inst(commit_pkg::FN_SUBU, rs, rt, rd);
            2:       return r_inst(commit_pkg::FN_AND, rs, rt, rd);
            3:       return r_inst(commit_pkg::FN_OR, rs, rt, rd);
            4:       return r_inst(commit_pkg::FN_XOR, rs, rt, rd);
            5:       return r_inst(commit_pkg::FN_SLT, rs, rt, rd);
            6, 7:    return i_inst(commit_pkg::OP_ADDIU, rs, rt, imm);
            8:       return i_inst(commit_pkg::OP_ORI, rs, rt, imm);
            9:       return i_inst(commit_pkg::OP_LUI, rs, rt, imm);
            10:      return r_inst(commit_pkg::FN_ADDU, rs, rt, 5'(take_bits(5)));
            11:      return i_inst(commit_pkg::OP_ADDIU, rs, 5'(take_bits(5)), imm);
            // any funct, mostly unsupported
            12:      return r_inst(6'(take_bits(6)), rs, rt, rd);
            // any word at all
            13:      return take_bits(32);
            14:      return r_inst(commit_pkg::FN_SLT, rs, rt, rd);
            default: return r_inst(commit_pkg::FN_SUBU, rs, rt, rd);
        endcase
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // next drive point, slots default to bubbles
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
        slot0 = '0;
        slot1 = '0;
    endtask

    // assumes issue_stall is low at this drive point
    task automatic drive_pair(input logic v0, input logic [31:0] i0,
                              input logic v1, input logic [31:0] i1);
        if (v0) begin
            slot0.valid = 1'b1;
            slot0.pc    = next_pc;
            slot0.inst  = commit_pkg::inst_u'(i0);
            record_slot(next_pc, i0);
            next_pc = next_pc + 32'd4;
        end
        if (v1) begin
            slot1.valid = 1'b1;
            slot1.pc    = next_pc;
            slot1.inst  = commit_pkg::inst_u'(i1);
            record_slot(next_pc, i1);
            next_pc = next_pc + 32'd4;
        end
    endtask

    // hold off while stalled, then issue for one cycle
    task automatic issue(input logic v0, input logic [31:0] i0,
                         input logic v1, input logic [31:0] i1);
        while (issue_stall) begin
            stall_seen = 1'b1;
            next_cycle();
        end
        drive_pair(v0, i0, v1, i1);
        next_cycle();
    endtask

    // wait for every expected record, bounded by the queue depth
    task automatic drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0) && (n < DRAIN_LIMIT)) begin
            next_cycle();
            n++;
        end
        // room for a stray extra record
        repeat (4) next_cycle();
    endtask

    // trace compare, outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!reset && (debug_wb_pc != '0)) begin
            if (exp_q.size() == 0) begin
                $display("unexpected retirement at %0t, pc %h with no record expected",
                         $time, debug_wb_pc);
                $display("Simulation failed");
                $fatal(1, "extra retirement");
            end else begin
                exp_rec = exp_q.pop_front();
                compare_field("debug_wb_pc", debug_wb_pc, exp_rec.pc);
                compare_field("debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'(exp_rec.wen));
                // number and data only mean something on a real write
                if (exp_rec.wen != '0) begin
                    compare_field("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum),
                                  32'(exp_rec.wnum));
                    compare_field("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_rec.wdata);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout, run went past %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        reset      = 1'b1;
        slot0      = '0;
        slot1      = '0;
        lfsr       = 32'hfee1f079;
        next_pc    = 32'hbfc00000;
        stall_seen = 1'b0;
        cycles     = 0;
        for (int i = 0; i < `COMMIT_NREGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;

        // idle after reset
        repeat (6) begin
            next_cycle();
            compare_field("debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'd0);
            compare_field("issue_stall", 32'(issue_stall), 32'd0);
            compare_field("debug_wb_pc", debug_wb_pc, 32'd0);
        end

        // every op alone, some in slot1
        issue(1'b1, i_inst(commit_pkg::OP_LUI, 5'd0, 5'd1, 16'h8765), 1'b0, '0);
        issue(1'b1, i_inst(commit_pkg::OP_ORI, 5'd1, 5'd1, 16'h4321), 1'b0, '0);
        issue(1'b1, i_inst(commit_pkg::OP_ADDIU, 5'd0, 5'd2, 16'hfff6), 1'b0, '0);
        issue(1'b1, r_inst(commit_pkg::FN_ADDU, 5'd1, 5'd2, 5'd3), 1'b0, '0);
        issue(1'b0, '0, 1'b1, r_inst(commit_pkg::FN_SUBU, 5'd1, 5'd2, 5'd4));
        issue(1'b1, r_inst(commit_pkg::FN_AND, 5'd1, 5'd3, 5'd5), 1'b0, '0);
        issue(1'b0, '0, 1'b1, r_inst(commit_pkg::FN_OR, 5'd2, 5'd1, 5'd6));
        issue(1'b1, r_inst(commit_pkg::FN_XOR, 5'd1, 5'd2, 5'd7), 1'b0, '0);
        issue(1'b1, r_inst(commit_pkg::FN_SLT, 5'd2, 5'd1, 5'd8), 1'b0, '0);
        issue(1'b1, r_inst(commit_pkg::FN_SLT, 5'd1, 5'd2, 5'd9), 1'b0, '0);
        issue(1'b1, i_inst(commit_pkg::OP_ORI, 5'd0, 5'd10, 16'hffff), 1'b0, '0);
        // r0 targets and unsupported encodings
        issue(1'b1, i_inst(commit_pkg::OP_ADDIU, 5'd1, 5'd0, 16'h0005), 1'b0, '0);
        issue(1'b1, r_inst(commit_pkg::FN_ADDU, 5'd1, 5'd1, 5'd0), 1'b0, '0);
        issue(1'b1, 32'hfc22_1234, 1'b0, '0);
        issue(1'b1, r_inst(6'b000000, 5'd1, 5'd2, 5'd11), 1'b0, '0);
        drain();

        // slot1 depends on slot0, next pair on both
        issue(1'b1, i_inst(commit_pkg::OP_ADDIU, 5'd0, 5'd11, 16'h0007),
              1'b1, r_inst(commit_pkg::FN_ADDU, 5'd11, 5'd11, 5'd12));
        issue(1'b1, r_inst(commit_pkg::FN_SUBU, 5'd12, 5'd11, 5'd13),
              1'b1, r_inst(commit_pkg::FN_SLT, 5'd11, 5'd12, 5'd14));
        // r0 write in slot0 does not forward
        issue(1'b1, i_inst(commit_pkg::OP_ADDIU, 5'd0, 5'd0, 16'h0009),
              1'b1, i_inst(commit_pkg::OP_ADDIU, 5'd0, 5'd15, 16'h0001));
        // same target in both slots, slot1 value stays
        issue(1'b1, i_inst(commit_pkg::OP_ADDIU, 5'd0, 5'd16, 16'h0111),
              1'b1, i_inst(commit_pkg::OP_ADDIU, 5'd0, 5'd16, 16'h0222));
        issue(1'b1, r_inst(commit_pkg::FN_ADDU, 5'd16, 5'd0, 5'd17), 1'b0, '0);
        drain();
        issue(1'b1, r_inst(commit_pkg::FN_OR, 5'd16, 5'd17, 5'd18), 1'b0, '0);
        drain();

        // full pairs back to back until the queue pushes back
        stall_seen = 1'b0;
        repeat (24) begin
            issue(1'b1, rand_inst(), 1'b1, rand_inst());
        end
        if (!stall_seen) begin
            $display("issue_stall never rose during back to back full pairs");
            $display("Simulation failed");
            $fatal(1, "no back-pressure");
        end
        drain();

        // random mix, bubbles and single slots, one cycle per step
        for (int i = 0; i < RAND_CYCLES; i++) begin
            if (!issue_stall && (take_bits(3) != 32'd0)) begin
                drive_pair(take_bits(1) != 32'd0, rand_inst(),
                           take_bits(1) != 32'd0, rand_inst());
            end
            next_cycle();
        end
        drain();

        if (exp_q.size() != 0) begin
            $display("%0d expected records never retired", exp_q.size());
            $display("Simulation failed");
            $fatal(1, "lost records");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule
